// File: logic/core_cfg_pkg.sv
/* Core-wide sizes. XLEN is both the data and the byte-address width. */
`default_nettype none

package core_cfg_pkg;

	localparam int XLEN  = 32;
	localparam int NREGS = 32; // x0 included

	// ADDI x0,x0,0
	localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// File: logic/decode_stage.sv
/* Decode stage. Registers operands and control under i_ce, holds on
   i_stall, and loads a NOP with o_ce low on i_flush. Register reads
   see the same-cycle writeback through the reg_file bypass. */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire [31:0]                    i_instr,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_pc,
	input  wire                           i_ce,
	input  wire                           i_stall,
	input  wire                           i_flush,
	input  wire                           i_wr,
	input  wire [4:0]                     i_rd,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_write_data,
	output logic [core_cfg_pkg::XLEN-1:0] o_rs1_data,
	output logic [core_cfg_pkg::XLEN-1:0] o_rs2_data,
	output logic [core_cfg_pkg::XLEN-1:0] o_imm_data,
	output rv_isa_pkg::opcode_e           o_opcode,
	output logic [2:0]                    o_func3,
	output rv_isa_pkg::alu_op_e           o_alu_ctrl,
	output logic [4:0]                    o_rd,
	output logic [core_cfg_pkg::XLEN-1:0] o_pc,
	output logic                          o_stall,
	output logic                          o_ce
);

	logic [31:0]                   d_instr; // NOP while flushing
	rv_isa_pkg::opcode_e           opc;
	logic [2:0]                    f3;
	logic [core_cfg_pkg::XLEN-1:0] rs1_data, rs2_data, imm;
	rv_isa_pkg::alu_op_e           alu;
	logic                          load;

	assign d_instr = i_flush ? core_cfg_pkg::NOP_INSTR : i_instr;
	assign opc     = rv_isa_pkg::opcode_e'(d_instr[6:0]);
	assign f3      = d_instr[rv_isa_pkg::F3_LSB +: 3];
	assign o_stall = i_stall; // fetch holds whenever execute does
	assign load    = i_flush || (i_ce && !i_stall);

	always_comb begin
		case (opc)
			rv_isa_pkg::OP_IMM, rv_isa_pkg::LOAD, rv_isa_pkg::JALR:
				imm = {{20{d_instr[31]}}, d_instr[31:20]};
			rv_isa_pkg::STORE:
				imm = {{20{d_instr[31]}}, d_instr[31:25], d_instr[11:7]};
			rv_isa_pkg::BRANCH:
				imm = {{19{d_instr[31]}}, d_instr[31], d_instr[7], d_instr[30:25],
					d_instr[11:8], 1'b0};
			rv_isa_pkg::LUI, rv_isa_pkg::AUIPC:
				imm = {d_instr[31:12], 12'b0};
			rv_isa_pkg::JAL:
				imm = {{11{d_instr[31]}}, d_instr[31], d_instr[19:12], d_instr[20],
					d_instr[30:21], 1'b0};
			default: imm = '0;
		endcase
	end

	always_comb begin
		alu = rv_isa_pkg::ALU_ADD; // addresses, targets, AUIPC
		if (opc == rv_isa_pkg::LUI)
			alu = rv_isa_pkg::ALU_PASS_B;
		else if (opc == rv_isa_pkg::OP || opc == rv_isa_pkg::OP_IMM) begin
			case (f3)
				3'b000: alu = (opc == rv_isa_pkg::OP && d_instr[rv_isa_pkg::F7_ALT]) ?
					rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD; // no SUBI
				3'b001: alu = rv_isa_pkg::ALU_SLL;
				3'b010: alu = rv_isa_pkg::ALU_SLT;
				3'b011: alu = rv_isa_pkg::ALU_SLTU;
				3'b100: alu = rv_isa_pkg::ALU_XOR;
				3'b101: alu = d_instr[rv_isa_pkg::F7_ALT] ?
					rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL; // bit 30 in both forms
				3'b110: alu = rv_isa_pkg::ALU_OR;
				default: alu = rv_isa_pkg::ALU_AND;
			endcase
		end
	end

	reg_file reg_file_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_rs1        (d_instr[rv_isa_pkg::RS1_LSB +: 5]),
		.i_rs2        (d_instr[rv_isa_pkg::RS2_LSB +: 5]),
		.i_wr         (i_wr),
		.i_rd         (i_rd),
		.i_write_data (i_write_data),
		.o_read_data1 (rs1_data),
		.o_read_data2 (rs2_data)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_ce <= 1'b0;
		else if (i_flush)
			o_ce <= 1'b0;
		else if (!i_stall)
			o_ce <= i_ce;
	end

	always_ff @(posedge clk) begin
		if (load) begin
			o_rs1_data <= rs1_data;
			o_rs2_data <= rs2_data;
			o_imm_data <= imm;
			o_opcode   <= opc;
			o_func3    <= f3;
			o_alu_ctrl <= alu;
			o_rd       <= d_instr[rv_isa_pkg::RD_LSB +: 5];
			o_pc       <= i_pc;
		end
	end

	// the flushed slot never reaches execute
	a_flush_kills: assert property (@(posedge clk) disable iff (!rst_n)
		i_flush |=> !o_ce);

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
/* Execute and writeback. ALU, branch and jump instructions retire the cycle
   after entry; LW/SW go through the arbiter and stall decode meanwhile.
   Branches resolve here, so a taken branch or jump flushes fetch/decode. */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           i_ce,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_rs1_data,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_rs2_data,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_imm_data,
	input  rv_isa_pkg::opcode_e           i_opcode,
	input  wire [2:0]                     i_func3,
	input  rv_isa_pkg::alu_op_e           i_alu_ctrl,
	input  wire [4:0]                     i_rd,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_pc,
	input  wire                           i_gnt,
	input  wire                           i_rvalid,
	input  wire [31:0]                    i_rdata,
	output logic                          o_req,
	output logic                          o_we,
	output logic [core_cfg_pkg::XLEN-1:0] o_addr,
	output logic [31:0]                   o_wdata,
	output logic                          o_stall,
	output logic                          o_flush,
	output logic [core_cfg_pkg::XLEN-1:0] o_redirect_pc,
	output logic                          o_wr,
	output logic [4:0]                    o_rd,
	output logic [core_cfg_pkg::XLEN-1:0] o_wr_data,
	output logic                          o_retire_valid,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_pc,
	output logic [4:0]                    o_retire_rd,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_data
);

	localparam int XLEN = core_cfg_pkg::XLEN;

	typedef enum logic [1:0] {IDLE, MEM_REQ, MEM_WAIT} state_e;
	state_e state;

	logic [XLEN-1:0] op_a, op_b, alu_res;
	logic            accept, is_mem, taken;
	logic [XLEN-1:0] m_pc;  // the memory op being sequenced
	logic [4:0]      m_rd;
	logic            ret_fire;
	logic [XLEN-1:0] ret_pc, ret_data;
	logic [4:0]      ret_rd;

	assign accept = i_ce && state == IDLE; // decode holds the next one while busy
	assign is_mem = i_opcode == rv_isa_pkg::LOAD || i_opcode == rv_isa_pkg::STORE;
	assign op_a   = (i_opcode == rv_isa_pkg::AUIPC || i_opcode == rv_isa_pkg::JAL) ?
		i_pc : i_rs1_data;
	assign op_b   = (i_opcode == rv_isa_pkg::OP) ? i_rs2_data : i_imm_data;

	always_comb begin
		case (i_alu_ctrl)
			rv_isa_pkg::ALU_ADD:    alu_res = op_a + op_b;
			rv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
			rv_isa_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
			rv_isa_pkg::ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			rv_isa_pkg::ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
			rv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
			rv_isa_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
			rv_isa_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
			rv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
			rv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
			rv_isa_pkg::ALU_PASS_B: alu_res = op_b;
			default:                alu_res = '0;
		endcase
	end

	always_comb begin
		case (rv_isa_pkg::br_funct3_e'(i_func3))
			rv_isa_pkg::BEQ: taken = i_rs1_data == i_rs2_data;
			rv_isa_pkg::BNE: taken = i_rs1_data != i_rs2_data;
			rv_isa_pkg::BLT: taken = $signed(i_rs1_data) < $signed(i_rs2_data);
			rv_isa_pkg::BGE: taken = $signed(i_rs1_data) >= $signed(i_rs2_data);
			default:         taken = 1'b0;
		endcase
	end

	// redirect in the resolve cycle, fetch drops the old path at once
	assign o_flush = accept && ((i_opcode == rv_isa_pkg::BRANCH && taken) ||
		i_opcode == rv_isa_pkg::JAL || i_opcode == rv_isa_pkg::JALR);
	assign o_redirect_pc = (i_opcode == rv_isa_pkg::BRANCH) ? i_pc + i_imm_data :
		{alu_res[XLEN-1:1], 1'b0}; // JALR clears bit 0

	assign o_req   = state == MEM_REQ;
	assign o_stall = state != IDLE;

	always_comb begin
		ret_fire = 1'b0;
		ret_pc   = i_pc;
		ret_rd   = i_rd;
		ret_data = alu_res;
		case (state)
			IDLE: if (accept && !is_mem) begin
				ret_fire = 1'b1;
				case (i_opcode)
					rv_isa_pkg::OP, rv_isa_pkg::OP_IMM, rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: ;
					rv_isa_pkg::JAL, rv_isa_pkg::JALR: ret_data = i_pc + 4; // link
					default: begin // branches and unknown opcodes write nothing
						ret_rd   = '0;
						ret_data = '0;
					end
				endcase
			end
			MEM_REQ: if (i_gnt && o_we) begin // store done once granted
				ret_fire = 1'b1;
				ret_pc   = m_pc;
				ret_rd   = '0;
				ret_data = o_wdata;
			end
			MEM_WAIT: if (i_rvalid) begin
				ret_fire = 1'b1;
				ret_pc   = m_pc;
				ret_rd   = m_rd;
				ret_data = i_rdata;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= IDLE;
			o_retire_valid <= 1'b0;
		end else begin
			o_retire_valid <= ret_fire;
			case (state)
				IDLE:     if (accept && is_mem) state <= MEM_REQ;
				MEM_REQ:  if (i_gnt) state <= o_we ? IDLE : MEM_WAIT;
				MEM_WAIT: if (i_rvalid) state <= IDLE;
				default:  state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept && is_mem) begin
			o_addr  <= alu_res;
			o_wdata <= i_rs2_data;
			o_we    <= i_opcode == rv_isa_pkg::STORE;
			m_pc    <= i_pc;
			m_rd    <= i_rd;
		end
		if (ret_fire) begin
			o_retire_pc   <= ret_pc;
			o_retire_rd   <= ret_rd;
			o_retire_data <= ret_data;
		end
	end

	// writeback in the retire cycle
	assign o_wr      = o_retire_valid && o_retire_rd != '0;
	assign o_rd      = o_retire_rd;
	assign o_wr_data = o_retire_data;

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
/* Instruction fetch. One request in flight at a time, so at best one
   instruction every two cycles. Only runs while i_run is high. */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter logic [core_cfg_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           i_run,
	input  wire                           i_stall,
	input  wire                           i_flush,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_redirect_pc,
	input  wire                           i_gnt,
	input  wire                           i_rvalid,
	input  wire [31:0]                    i_rdata,
	output logic                          o_req,
	output logic [core_cfg_pkg::XLEN-1:0] o_addr,
	output logic [31:0]                   o_instr,
	output logic [core_cfg_pkg::XLEN-1:0] o_pc,
	output logic                          o_ce
);

	logic [core_cfg_pkg::XLEN-1:0] pc;     // next pc to request
	logic [core_cfg_pkg::XLEN-1:0] req_pc; // pc of the request in flight
	logic                          wait_rsp;
	logic                          take;   // output register free or being consumed

	assign o_req  = i_run && !wait_rsp && !i_stall && !i_flush;
	assign o_addr = pc;
	assign take   = !i_stall || !o_ce;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= RESET_PC;
			wait_rsp <= 1'b0;
			o_ce     <= 1'b0;
			o_instr  <= core_cfg_pkg::NOP_INSTR;
		end else begin
			wait_rsp <= o_req && i_gnt; // data comes back next cycle
			if (i_flush)
				pc <= i_redirect_pc;
			else if (o_req && i_gnt)
				pc <= pc + 4;
			// a response landing in the flush cycle is from the old path, drop it
			if (i_flush) begin
				o_ce    <= 1'b0;
				o_instr <= core_cfg_pkg::NOP_INSTR;
			end else if (take) begin
				o_ce    <= i_rvalid;
				o_instr <= i_rvalid ? i_rdata : core_cfg_pkg::NOP_INSTR;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (o_req && i_gnt)
			req_pc <= pc;
		if (take && i_rvalid)
			o_pc <= req_pc;
	end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
/* Fixed priority puts data before fetch, and data can starve fetch.
   Grants are combinational, read data returns one cycle later to its owner.
   Requesters pass byte addresses, the RAM gets word addresses. */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int MEM_WORDS = 256
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          i_if_req,
	input  wire [core_cfg_pkg::XLEN-1:0] i_if_addr,
	output logic                         o_if_gnt,
	output logic                         o_if_rvalid,
	output logic [31:0]                  o_if_rdata,
	input  wire                          i_d_req,
	input  wire                          i_d_we,
	input  wire [core_cfg_pkg::XLEN-1:0] i_d_addr,
	input  wire [31:0]                   i_d_wdata,
	output logic                         o_d_gnt,
	output logic                         o_d_rvalid,
	output logic [31:0]                  o_d_rdata,
	output logic                         o_mem_en,
	output logic                         o_mem_we,
	output logic [$clog2(MEM_WORDS)-1:0] o_mem_addr,
	output logic [31:0]                  o_mem_wdata,
	input  wire [31:0]                   i_mem_rdata
);

	localparam int AW = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {OWN_NONE, OWN_IF, OWN_DATA} owner_e;
	owner_e owner; // who gets the ram output this cycle

	assign o_d_gnt     = i_d_req;
	assign o_if_gnt    = i_if_req && !i_d_req;
	assign o_mem_en    = i_d_req || i_if_req;
	assign o_mem_we    = o_d_gnt && i_d_we;
	assign o_mem_addr  = o_d_gnt ? i_d_addr[AW+1:2] : i_if_addr[AW+1:2];
	assign o_mem_wdata = i_d_wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			owner <= OWN_NONE;
		else if (o_d_gnt && !i_d_we)
			owner <= OWN_DATA;
		else if (o_if_gnt)
			owner <= OWN_IF;
		else
			owner <= OWN_NONE; // writes return nothing
	end

	assign o_if_rvalid = owner == OWN_IF;
	assign o_if_rdata  = i_mem_rdata;
	assign o_d_rvalid  = owner == OWN_DATA;
	assign o_d_rdata   = i_mem_rdata;

	a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
		!(o_if_gnt && o_d_gnt));

endmodule

`default_nettype wire

// File: logic/reg_file.sv
/* 31 writable registers, x0 reads zero. Reads are combinational and
   return the data being written in the same cycle. No reset on contents. */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire [4:0]                     i_rs1,
	input  wire [4:0]                     i_rs2,
	input  wire                           i_wr,
	input  wire [4:0]                     i_rd,
	input  wire [core_cfg_pkg::XLEN-1:0]  i_write_data,
	output logic [core_cfg_pkg::XLEN-1:0] o_read_data1,
	output logic [core_cfg_pkg::XLEN-1:0] o_read_data2
);

	logic [core_cfg_pkg::XLEN-1:0] regs [1:core_cfg_pkg::NREGS-1];

	always_ff @(posedge clk) begin
		if (i_wr && i_rd != '0)
			regs[i_rd] <= i_write_data;
	end

	// write-through so a dependent instruction in decode needs no stall
	assign o_read_data1 = (i_rs1 == '0) ? '0 :
		(i_wr && i_rd == i_rs1) ? i_write_data : regs[i_rs1];
	assign o_read_data2 = (i_rs2 == '0) ? '0 :
		(i_wr && i_rd == i_rs2) ? i_write_data : regs[i_rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(i_wr && i_rd == '0) |=> (i_rs1 != '0 || o_read_data1 == '0));

endmodule

`default_nettype wire

// File: logic/rv_core_top.sv
/* Three-stage RV32I core with one shared RAM. Hold rst_n or i_run low while
   loading the program; i_load_addr is a word address. Fetch starts at RESET_PC. */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
	parameter int                            MEM_WORDS = 256,
	parameter logic [core_cfg_pkg::XLEN-1:0] RESET_PC  = '0
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           i_run,
	input  wire                           i_load_we,
	input  wire [$clog2(MEM_WORDS)-1:0]   i_load_addr,
	input  wire [31:0]                    i_load_data,
	output logic                          o_retire_valid,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_pc,
	output logic [4:0]                    o_retire_rd,
	output logic [core_cfg_pkg::XLEN-1:0] o_retire_data
);

	localparam int XLEN = core_cfg_pkg::XLEN;
	localparam int AW   = $clog2(MEM_WORDS);

	// fetch side
	logic            if_req, if_gnt, if_rvalid, f_ce;
	logic [XLEN-1:0] if_addr, f_pc;
	logic [31:0]     if_rdata, f_instr;
	// decode to execute
	logic [XLEN-1:0]     d_rs1, d_rs2, d_imm, d_pc;
	rv_isa_pkg::opcode_e d_opcode;
	rv_isa_pkg::alu_op_e d_alu;
	logic [2:0]          d_func3;
	logic [4:0]          d_rd;
	logic                d_ce, d_stall;
	// execute control and writeback
	logic            ex_stall, flush, wb_wr;
	logic [XLEN-1:0] redirect_pc, wb_data;
	logic [4:0]      wb_rd;
	// data port and ram
	logic            dm_req, dm_we, dm_gnt, dm_rvalid;
	logic [XLEN-1:0] dm_addr;
	logic [31:0]     dm_wdata, dm_rdata;
	logic            mem_en, mem_we;
	logic [AW-1:0]   mem_addr;
	logic [31:0]     mem_wdata, mem_rdata;

	fetch_stage #(.RESET_PC(RESET_PC)) fetch_stage_inst (
		.clk(clk), .rst_n(rst_n), .i_run(i_run),
		.i_stall(d_stall), .i_flush(flush), .i_redirect_pc(redirect_pc),
		.i_gnt(if_gnt), .i_rvalid(if_rvalid), .i_rdata(if_rdata),
		.o_req(if_req), .o_addr(if_addr),
		.o_instr(f_instr), .o_pc(f_pc), .o_ce(f_ce)
	);

	decode_stage decode_stage_inst (
		.clk(clk), .rst_n(rst_n),
		.i_instr(f_instr), .i_pc(f_pc), .i_ce(f_ce),
		.i_stall(ex_stall), .i_flush(flush),
		.i_wr(wb_wr), .i_rd(wb_rd), .i_write_data(wb_data),
		.o_rs1_data(d_rs1), .o_rs2_data(d_rs2), .o_imm_data(d_imm),
		.o_opcode(d_opcode), .o_func3(d_func3), .o_alu_ctrl(d_alu),
		.o_rd(d_rd), .o_pc(d_pc), .o_stall(d_stall), .o_ce(d_ce)
	);

	execute_stage execute_stage_inst (
		.clk(clk), .rst_n(rst_n), .i_ce(d_ce),
		.i_rs1_data(d_rs1), .i_rs2_data(d_rs2), .i_imm_data(d_imm),
		.i_opcode(d_opcode), .i_func3(d_func3), .i_alu_ctrl(d_alu),
		.i_rd(d_rd), .i_pc(d_pc),
		.i_gnt(dm_gnt), .i_rvalid(dm_rvalid), .i_rdata(dm_rdata),
		.o_req(dm_req), .o_we(dm_we), .o_addr(dm_addr), .o_wdata(dm_wdata),
		.o_stall(ex_stall), .o_flush(flush), .o_redirect_pc(redirect_pc),
		.o_wr(wb_wr), .o_rd(wb_rd), .o_wr_data(wb_data),
		.o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
		.o_retire_rd(o_retire_rd), .o_retire_data(o_retire_data)
	);

	mem_arbiter #(.MEM_WORDS(MEM_WORDS)) mem_arbiter_inst (
		.clk(clk), .rst_n(rst_n),
		.i_if_req(if_req), .i_if_addr(if_addr), .o_if_gnt(if_gnt),
		.o_if_rvalid(if_rvalid), .o_if_rdata(if_rdata),
		.i_d_req(dm_req), .i_d_we(dm_we), .i_d_addr(dm_addr), .i_d_wdata(dm_wdata),
		.o_d_gnt(dm_gnt), .o_d_rvalid(dm_rvalid), .o_d_rdata(dm_rdata),
		.o_mem_en(mem_en), .o_mem_we(mem_we), .o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata)
	);

	shared_ram #(.MEM_WORDS(MEM_WORDS)) shared_ram_inst (
		.clk(clk), .i_en(mem_en), .i_we(mem_we), .i_addr(mem_addr),
		.i_wdata(mem_wdata), .o_rdata(mem_rdata),
		.i_load_we(i_load_we), .i_load_addr(i_load_addr), .i_load_data(i_load_data)
	);

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
/* RV32I encodings for the subset this core runs.
   Opcodes outside opcode_e retire as no-ops with rd 0. */
`default_nettype none

package rv_isa_pkg;

	// major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OP     = 7'b0110011, // register-register alu
		OP_IMM = 7'b0010011, // register-immediate alu
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011, // LW only
		STORE  = 7'b0100011, // SW only
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111
	} opcode_e;

	// alu operations, built in decode from opcode/funct3/funct7
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_PASS_B // operand b straight through, for LUI
	} alu_op_e;

	// funct3 of the supported branches
	typedef enum logic [2:0] {
		BEQ = 3'b000,
		BNE = 3'b001,
		BLT = 3'b100,
		BGE = 3'b101
	} br_funct3_e;

	// field positions
	localparam int RD_LSB  = 7;
	localparam int F3_LSB  = 12;
	localparam int RS1_LSB = 15;
	localparam int RS2_LSB = 20;
	localparam int F7_ALT  = 30; // funct7 bit that selects SUB / SRA

endpackage

`default_nettype wire

// File: logic/shared_ram.sv
/* Single-port word RAM with registered read. The load port wins over the
   core port and should only be used while the core is held. */
`timescale 1ns/1ps
`default_nettype none

module shared_ram #(
	parameter int MEM_WORDS = 256
) (
	input  wire                          clk,
	input  wire                          i_en,
	input  wire                          i_we,
	input  wire [$clog2(MEM_WORDS)-1:0]  i_addr,
	input  wire [31:0]                   i_wdata,
	output logic [31:0]                  o_rdata,
	input  wire                          i_load_we,
	input  wire [$clog2(MEM_WORDS)-1:0]  i_load_addr,
	input  wire [31:0]                   i_load_data
);

	logic [31:0] mem [0:MEM_WORDS-1];

	always_ff @(posedge clk) begin
		if (i_load_we)
			mem[i_load_addr] <= i_load_data; // program load
		else if (i_en && i_we)
			mem[i_addr] <= i_wdata;
		else if (i_en)
			o_rdata <= mem[i_addr]; // valid the cycle after the access
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f rv_core.f \
	--top-module rv_core_tb \
	-Mdir obj_dir -o rv_core_sim

./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi

// File: rv_core.f
logic/rv_isa_pkg.sv
logic/core_cfg_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_arbiter.sv
logic/shared_ram.sv
logic/rv_core_top.sv
+incdir+tb
tb/rv_core_tb.sv

// File: tb/rv_core_programs.svh
/* Test programs for rv_core_tb with the expected retire sequence
   (pc, rd, data) of each. Data area starts at byte 0x200. */
`ifndef RV_CORE_PROGRAMS_SVH
`define RV_CORE_PROGRAMS_SVH

task automatic build_test(int t);
	bit [31:0] a, b, r, x3v, av, cv;
	int        i, f, f3, sh;
	int        f3_imm_list [6] = '{0, 2, 3, 4, 6, 7}; // ADDI SLTI SLTIU XORI ORI ANDI
	bit        alt;
	prog.delete();
	exp_pc.delete();
	exp_rd.delete();
	exp_data.delete();
	case (t)
		0: begin // alu ops on random operands
			for (i = 0; i < 2; i++) begin
				a = lcg_next();
				b = lcg_next();
				load_const(1, a);
				load_const(2, b);
				for (f = 0; f < 10; f++) begin
					f3  = (f < 8) ? f : ((f == 8) ? 0 : 5); // 8 is SUB, 9 is SRA
					alt = f >= 8;
					x3v = ref_alu(f3, alt, a, b);
					put(enc_r(alt ? 32'h20 : 0, 2, 1, f3, 3, OPC_OP));
					want(3, x3v);
				end
				foreach (f3_imm_list[j]) begin
					r = lcg_next();
					put(enc_i(int'(r[11:0]), 1, f3_imm_list[j], 4, OPC_IMM));
					want(4, ref_alu(f3_imm_list[j], 1'b0, a, sext12(r[11:0])));
				end
				for (f = 0; f < 3; f++) begin // SLLI, SRLI, SRAI
					r   = lcg_next();
					sh  = int'(r[4:0]);
					f3  = (f == 0) ? 1 : 5;
					alt = f == 2;
					put(enc_i(alt ? (32'h400 | sh) : sh, 1, f3, 4, OPC_IMM));
					want(4, ref_alu(f3, alt, a, {27'b0, r[4:0]}));
				end
				put(enc_r(0, 1, 3, 0, 5, OPC_OP)); // dependent chain x3 -> x5 -> x6
				want(5, x3v + a);
				put(enc_r(0, 5, 5, 0, 6, OPC_OP));
				want(6, (x3v + a) + (x3v + a));
				put(enc_i(7, 1, 0, 0, OPC_IMM)); // write to x0
				want(0, a + 7);
				put(enc_r(0, 0, 0, 0, 6, OPC_OP));
				want(6, 32'h0);
			end
		end
		1: begin // upper immediates
			put(enc_u(32'h12345, 1, OPC_LUI));
			want(1, 32'h1234_5000);
			put(enc_u(32'h00001, 2, OPC_AUIPC));
			want(2, 32'h0000_1004);
			put(enc_u(32'hFFFFF, 3, OPC_AUIPC));
			want(3, 32'hFFFF_F008);
			put(enc_u(32'h80000, 4, OPC_LUI));
			want(4, 32'h8000_0000);
		end
		2: begin // SW / LW
			put(enc_i(32'h200, 0, 0, 1, OPC_IMM));
			want(1, 32'h200);
			load_const(2, 32'hDEAD_BEEF);
			put(enc_s(0, 2, 1));
			want(0, 32'hDEAD_BEEF);
			put(enc_i(32'h5A5, 0, 0, 3, OPC_IMM));
			want(3, 32'h5A5);
			put(enc_s(4, 3, 1));
			want(0, 32'h5A5);
			put(enc_i(0, 1, 2, 4, OPC_LOAD));
			want(4, 32'hDEAD_BEEF);
			put(enc_i(4, 1, 2, 5, OPC_LOAD));
			want(5, 32'h5A5);
			put(enc_s(8, 4, 1)); // store of a just-loaded value
			want(0, 32'hDEAD_BEEF);
			put(enc_i(8, 1, 2, 6, OPC_LOAD));
			want(6, 32'hDEAD_BEEF);
			put(enc_r(0, 5, 6, 0, 7, OPC_OP));
			want(7, 32'hDEAD_BEEF + 32'h5A5);
		end
		3: begin // branches with x1 = 5 and x2 = -3
			put(enc_i(5, 0, 0, 1, OPC_IMM));
			want(1, 32'd5);
			put(enc_i(-3, 0, 0, 2, OPC_IMM));
			want(2, 32'hFFFF_FFFD);
			put(enc_b(8, 2, 1, 0)); // BEQ not taken
			want(0, 0);
			put(enc_b(8, 2, 1, 1)); // BNE taken
			want(0, 0);
			put(enc_i(1, 0, 0, 3, OPC_IMM)); // skipped
			put(enc_b(8, 1, 2, 4)); // BLT -3 < 5 taken
			want(0, 0);
			put(enc_i(2, 0, 0, 3, OPC_IMM)); // skipped
			put(enc_b(8, 1, 2, 5)); // BGE not taken
			want(0, 0);
			put(enc_b(8, 2, 1, 4)); // BLT not taken
			want(0, 0);
			put(enc_b(8, 2, 1, 5)); // BGE taken
			want(0, 0);
			put(enc_i(3, 0, 0, 3, OPC_IMM)); // skipped
			put(enc_b(8, 1, 1, 0)); // BEQ taken
			want(0, 0);
			put(enc_i(4, 0, 0, 3, OPC_IMM)); // skipped
			put(enc_i(9, 0, 0, 4, OPC_IMM));
			want(4, 32'd9);
		end
		4: begin // jumps
			put(enc_j(12, 1));
			want(1, 32'd4);
			put(enc_i(1, 0, 0, 5, OPC_IMM)); // skipped
			put(enc_i(2, 0, 0, 5, OPC_IMM)); // skipped
			put(enc_i(28, 0, 0, 2, OPC_IMM));
			want(2, 32'd28);
			put(enc_i(0, 2, 0, 3, OPC_JALR));
			want(3, 32'd20);
			put(enc_i(1, 0, 0, 5, OPC_IMM)); // skipped
			put(enc_i(2, 0, 0, 5, OPC_IMM)); // skipped
			put(enc_i(9, 2, 0, 4, OPC_JALR)); // 37 with bit 0 cleared
			want(4, 32'd32);
			put(enc_i(3, 0, 0, 5, OPC_IMM)); // skipped
			put(enc_i(7, 0, 0, 6, OPC_IMM));
			want(6, 32'd7);
		end
		default: begin // store/load loop over three passes
			put(enc_i(32'h200, 0, 0, 1, OPC_IMM));
			want(1, 32'h200);
			put(enc_i(3, 0, 0, 2, OPC_IMM));
			want(2, 32'd3);
			put(enc_s(0, 2, 1));
			put(enc_i(0, 1, 2, 3, OPC_LOAD));
			put(enc_i(4, 1, 0, 1, OPC_IMM));
			put(enc_i(-1, 2, 0, 2, OPC_IMM));
			put(enc_b(-16, 0, 2, 1)); // back to the SW while x2 != 0
			put(enc_i(-4, 1, 2, 4, OPC_LOAD));
			av = 32'h200;
			cv = 32'd3;
			for (i = 0; i < 3; i++) begin
				want_at(8, 0, cv);
				want_at(12, 3, cv);
				av = av + 4;
				want_at(16, 1, av);
				cv = cv - 1;
				want_at(20, 2, cv);
				want_at(24, 0, 0);
			end
			want_at(28, 4, 32'd1);
		end
	endcase
	put(enc_j(0, 0)); // park on a jump to itself
	want(0, last_pc + 4);
endtask

`endif

// File: tb/rv_core_tb.sv
/* Testbench for rv_core_top. Runs each program of the test table from reset
   and compares every retire event in order. Programs end in a JAL-to-self loop,
   of which only the first retire is checked. */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

	localparam int MEM_WORDS = 256;
	localparam int NTESTS    = 6;
	localparam int RET_WAIT  = 100; // cycles allowed between two retires

	// RV32I major opcodes
	localparam bit [6:0] OPC_OP    = 7'h33;
	localparam bit [6:0] OPC_IMM   = 7'h13;
	localparam bit [6:0] OPC_LUI   = 7'h37;
	localparam bit [6:0] OPC_AUIPC = 7'h17;
	localparam bit [6:0] OPC_LOAD  = 7'h03;
	localparam bit [6:0] OPC_STORE = 7'h23;
	localparam bit [6:0] OPC_BR    = 7'h63;
	localparam bit [6:0] OPC_JAL   = 7'h6F;
	localparam bit [6:0] OPC_JALR  = 7'h67;

	logic        clk;
	logic        rst_n;
	logic        i_run;
	logic        i_load_we;
	logic [7:0]  i_load_addr;
	logic [31:0] i_load_data;
	logic        o_retire_valid;
	logic [31:0] o_retire_pc;
	logic [4:0]  o_retire_rd;
	logic [31:0] o_retire_data;

	bit [31:0] prog[$];     // instruction words from address 0
	bit [31:0] exp_pc[$];   // expected retire sequence
	bit [4:0]  exp_rd[$];
	bit [31:0] exp_data[$];
	bit [31:0] last_pc;
	bit [31:0] rng;
	int        checks;
	int        val_errs;
	int        timeouts;

	rv_core_top #(.MEM_WORDS(MEM_WORDS), .RESET_PC(32'h0)) rv_core_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_run          (i_run),
		.i_load_we      (i_load_we),
		.i_load_addr    (i_load_addr),
		.i_load_data    (i_load_data),
		.o_retire_valid (o_retire_valid),
		.o_retire_pc    (o_retire_pc),
		.o_retire_rd    (o_retire_rd),
		.o_retire_data  (o_retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	function automatic bit [31:0] lcg_next();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	// instruction encoders, immediates given as plain integers
	function automatic bit [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd, bit [6:0] op);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic bit [31:0] enc_i(int imm, int rs1, int f3, int rd, bit [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic bit [31:0] enc_s(int off, int rs2, int rs1);
		return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OPC_STORE}; // SW
	endfunction

	function automatic bit [31:0] enc_b(int off, int rs2, int rs1, int f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BR};
	endfunction

	function automatic bit [31:0] enc_u(int imm20, int rd, bit [6:0] op);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic bit [31:0] enc_j(int off, int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	function automatic bit [31:0] sext12(bit [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// RV32I integer result by funct3, alt selects SUB / SRA
	function automatic bit [31:0] ref_alu(int f3, bit alt, bit [31:0] a, bit [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			0: return alt ? a - b : a + b;
			1: return a << b[4:0];
			2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3: return (a < b) ? 32'd1 : 32'd0;
			4: return a ^ b;
			5: return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
			6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic put(bit [31:0] word);
		last_pc = prog.size() * 4;
		prog.push_back(word);
	endtask

	task automatic want_at(bit [31:0] pc, int rd, bit [31:0] data);
		exp_pc.push_back(pc);
		exp_rd.push_back(rd[4:0]);
		exp_data.push_back(data);
	endtask

	task automatic want(int rd, bit [31:0] data);
		want_at(last_pc, rd, data);
	endtask

	// LUI + ADDI, the upper part absorbs the sign of the low 12 bits
	task automatic load_const(int rd, bit [31:0] v);
		bit [31:0] hi;
		hi = (v + 32'h800) & 32'hFFFF_F000;
		put(enc_u(int'(hi[31:12]), rd, OPC_LUI));
		want(rd, hi);
		put(enc_i(int'(v[11:0]), rd, 0, rd, OPC_IMM));
		want(rd, v);
	endtask

	`include "rv_core_programs.svh"

	task automatic run_test(int t);
		int  k;
		int  cnt;
		bit  got;
		bit  lost;
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		i_run = 1'b0;
		repeat (5) begin
			@(posedge clk);
			#1;
		end
		for (k = 0; k < prog.size(); k++) begin // load while still in reset
			i_load_we   = 1'b1;
			i_load_addr = k[7:0];
			i_load_data = prog[k];
			@(posedge clk);
			#1;
		end
		i_load_we = 1'b0;
		rst_n     = 1'b1;
		@(posedge clk);
		#1;
		i_run = 1'b1;
		lost  = 1'b0;
		for (k = 0; k < exp_pc.size() && !lost; k++) begin
			got = 1'b0;
			for (cnt = 0; cnt < RET_WAIT && !got; cnt++) begin
				@(negedge clk); // retire outputs settle after the rising edge
				got = o_retire_valid;
			end
			if (!got) begin
				$display("test %0d: no retire within %0d cycles, expected entry %0d at pc %h",
					t, RET_WAIT, k, exp_pc[k]);
				timeouts++;
				lost = 1'b1;
			end else begin
				checks++;
				if (o_retire_pc !== exp_pc[k]) begin
					$display("Fail %0t: test %0d entry %0d pc %h, expected %h",
						$time, t, k, o_retire_pc, exp_pc[k]);
					val_errs++;
				end
				if (o_retire_rd !== exp_rd[k]) begin
					$display("Fail %0t: test %0d pc %h rd %0d, expected %0d",
						$time, t, exp_pc[k], o_retire_rd, exp_rd[k]);
					val_errs++;
				end
				if (o_retire_data !== exp_data[k]) begin
					$display("Fail %0t: test %0d pc %h data %h, expected %h",
						$time, t, exp_pc[k], o_retire_data, exp_data[k]);
					val_errs++;
				end
			end
		end
		@(posedge clk);
		#1;
		i_run = 1'b0;
		rst_n = 1'b0;
	endtask

	initial begin
		int t;
		rst_n       = 1'b0;
		i_run       = 1'b0;
		i_load_we   = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		rng         = 32'h0415_e4dd;
		checks      = 0;
		val_errs    = 0;
		timeouts    = 0;
		for (t = 0; t < NTESTS; t++) begin
			build_test(t);
			run_test(t);
		end
		$display("retires checked %0d, wrong values %0d, timeouts %0d",
			checks, val_errs, timeouts);
		if (val_errs == 0 && timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
